//--- Bender.yml
package:
  name: iwm

sources:
  - iwmPkg.sv
  - floppyDrive.sv
  - readLatch.sv
  - iwmRegs.sv
  - iwm.sv
  - target: test
    files:
      - iwm_chk.sv
      - tb_iwm.sv

//--- filelist.f
iwmPkg.sv
floppyDrive.sv
readLatch.sv
iwmRegs.sv
iwm.sv
iwm_chk.sv
tb_iwm.sv

//--- floppyDrive.sv
// drive model with no media behind it; bytes are synthetic and BytePeriod must be at least 2
`timescale 1ns/1ps

module floppyDrive #(
	parameter int BytePeriod = 128,
	parameter int TrackSeed = 0
) (
	input logic clk8,
	input logic _reset,
	input iwmPkg::driveCtrl_t ctrl,
	input logic insertDisk,  // one-cycle strobe
	output iwmPkg::driveStatus_t status,
	output logic inserted
);
	import iwmPkg::*;

	localparam int TimerW = $clog2(BytePeriod);
	localparam logic [TimerW-1:0] LastTick = TimerW'(BytePeriod - 1);
	localparam logic [6:0] SeedLow = 7'(TrackSeed); // only the low seven bits matter

	logic [3:0] senseIndex;
	logic senseBit;
	logic lstrbPrev;
	logic ejectStrobe;
	logic streaming;
	logic byteDue;
	logic [TimerW-1:0] byteTimer;
	logic [6:0] byteCount;  // bytes sent since the last insertion, wraps
	logic byteReady;
	logic [7:0] byteReg;

	assign senseIndex = {ctrl.ca2, ctrl.ca1, ctrl.ca0, ctrl.sel};
	assign ejectStrobe = ctrl.lstrb & ~lstrbPrev & (senseIndex == EjectCode); // lstrb rise
	assign streaming = ctrl.enable & inserted;
	assign byteDue = streaming && (byteTimer == LastTick);

	// sense answers, unlisted indices float high
	always_comb begin
		case (senseIndex)
			SenseNoDisk: senseBit = ~inserted;
			SenseEnabled: senseBit = ~ctrl.enable;
			default: senseBit = 1'b1;
		endcase
	end

	// disk presence
	always_ff @(posedge clk8 or negedge _reset) begin
		if (!_reset) begin
			inserted <= 1'b0;
			lstrbPrev <= 1'b0;
		end else begin
			lstrbPrev <= ctrl.lstrb;
			if (insertDisk)
				inserted <= 1'b1;     // insertion wins over a same-cycle eject
			else if (ejectStrobe)
				inserted <= 1'b0;
		end
	end

	// byte pacing
	always_ff @(posedge clk8 or negedge _reset) begin
		if (!_reset) begin
			byteTimer <= '0;
			byteCount <= '0;
			byteReady <= 1'b0;
		end else begin
			byteReady <= 1'b0; // strobe by default
			if (insertDisk) begin
				byteTimer <= '0;
				byteCount <= '0; // fresh disk restarts the sequence
			end else if (!streaming) begin
				byteTimer <= '0;  // idle drive holds its position in the sequence
			end else if (byteDue) begin
				byteTimer <= '0;
				byteReady <= 1'b1;
				byteCount <= byteCount + 1'b1;
			end else begin
				byteTimer <= byteTimer + 1'b1;
			end
		end
	end

	// payload, MSB always set like real GCR data
	always_ff @(posedge clk8) begin
		if (byteDue && !insertDisk)
			byteReg <= {1'b1, SeedLow + byteCount};
	end

	assign status = '{byteReady: byteReady, readByte: byteReg, sense: senseBit};

endmodule

//--- iwm.sv
// IWM controller with internal and external drive; dataOut is combinational during the access
`timescale 1ns/1ps

module iwm #(
	parameter int BytePeriod = 128,  // clk8 cycles per streamed byte
	parameter int IntSeed = 0,       // first byte low bits, internal drive
	parameter int ExtSeed = 64       // same for the external drive
) (
	input logic clk8,
	input logic _reset,
	input iwmPkg::cpuAccess_t cpu,
	input logic sel,                 // head select from the VIA
	input logic [1:0] insertDisk,    // [0] internal, [1] external
	output logic [15:0] dataOut,
	output logic [1:0] diskInDrive
);
	import iwmPkg::*;

	driveCtrl_t ctrlInt, ctrlExt;
	driveStatus_t statusInt, statusExt;
	logic selectExt;
	logic readStrobe;
	logic [7:0] latchByte;
	logic sense;

	iwmRegs regs (
		.clk8(clk8),
		._reset(_reset),
		.cpu(cpu),
		.sel(sel),
		.latchByte(latchByte),
		.sense(sense),
		.ctrlInt(ctrlInt),
		.ctrlExt(ctrlExt),
		.selectExt(selectExt),
		.readStrobe(readStrobe),
		.dataOut(dataOut)
	);

	floppyDrive #(.BytePeriod(BytePeriod), .TrackSeed(IntSeed)) driveInt (
		.clk8(clk8),
		._reset(_reset),
		.ctrl(ctrlInt),
		.insertDisk(insertDisk[0]),
		.status(statusInt),
		.inserted(diskInDrive[0])
	);

	floppyDrive #(.BytePeriod(BytePeriod), .TrackSeed(ExtSeed)) driveExt (
		.clk8(clk8),
		._reset(_reset),
		.ctrl(ctrlExt),
		.insertDisk(insertDisk[1]),
		.status(statusExt),
		.inserted(diskInDrive[1])
	);

	readLatch latch (
		.clk8(clk8),
		._reset(_reset),
		.statusInt(statusInt),
		.statusExt(statusExt),
		.selectExt(selectExt),
		.readStrobe(readStrobe),
		.latchByte(latchByte),
		.sense(sense)
	);

endmodule

//--- iwmPkg.sv
// shared IWM types and constants; struct field order is the bit order seen by every block
package iwmPkg;

	// one CPU access, valid only in the cycle strobe is high
	typedef struct packed {
		logic strobe;       // access happens this cycle
		logic write;        // 1 = write, 0 = read
		logic [3:0] addr;   // [3:1] switch number, [0] new switch value
		logic [7:0] data;   // low data byte, only [4:0] reach the mode register
	} cpuAccess_t;

	// lines fanned out to both drives
	typedef struct packed {
		logic ca0;
		logic ca1;
		logic ca2;
		logic lstrb;  // phase 3, rising edge is the command strobe
		logic sel;    // head select from the VIA
		logic enable; // per drive, differs between the two instances
	} driveCtrl_t;

	// what one drive hands back
	typedef struct packed {
		logic byteReady;     // single-cycle strobe
		logic [7:0] readByte;
		logic sense;         // answer to the current sense index
	} driveStatus_t;

	// mode register, stored and read back only
	typedef struct packed {
		logic speed;
		logic bitCell;
		logic motorDelay;
		logic asyncHandshake;
		logic latchMode;
	} iwmMode_t;

	localparam int LatchClearCycles = 14;     // qualifying read to latch reading zero
	localparam logic [7:0] DataOutHigh = 8'hBE; // fixed upper byte of every read

	// sense and command index is {ca2, ca1, ca0, sel}
	localparam logic [3:0] EjectCode = 4'hE;
	localparam logic [3:0] SenseNoDisk = 4'd2;  // low while a disk is inserted
	localparam logic [3:0] SenseEnabled = 4'd4; // low while the drive is enabled

endpackage

//--- iwmRegs.sv
// IWM soft switches and read-back; data writes with a drive enabled are dropped
`timescale 1ns/1ps

module iwmRegs (
	input logic clk8,
	input logic _reset,
	input iwmPkg::cpuAccess_t cpu,
	input logic sel,
	input logic [7:0] latchByte,
	input logic sense,
	output iwmPkg::driveCtrl_t ctrlInt,
	output iwmPkg::driveCtrl_t ctrlExt,
	output logic selectExt,
	output logic readStrobe,
	output logic [15:0] dataOut
);
	import iwmPkg::*;

	localparam logic [7:0] HandshakeIdle = 8'hC0; // buffer empty, no underrun

	logic ca0, ca1, ca2, lstrb, enInt, enExt, q6, q7;
	logic ca0Next, ca1Next, ca2Next, lstrbNext, enIntNext, enExtNext, q6Next, q7Next;
	logic selectExtNext;
	logic anyEnabled;
	logic modeWrite;
	iwmMode_t mode;
	logic [7:0] dataLo;

	// every access flips one switch, reads included
	always_comb begin
		ca0Next = ca0;
		ca1Next = ca1;
		ca2Next = ca2;
		lstrbNext = lstrb;
		enIntNext = enInt;
		enExtNext = enExt;
		selectExtNext = selectExt;
		q6Next = q6;
		q7Next = q7;
		if (cpu.strobe) begin
			case (cpu.addr[3:1])
				3'd0: ca0Next = cpu.addr[0];
				3'd1: ca1Next = cpu.addr[0];
				3'd2: ca2Next = cpu.addr[0];
				3'd3: lstrbNext = cpu.addr[0];
				3'd4: begin
					// motor switch goes to whichever drive is selected now
					if (selectExt)
						enExtNext = cpu.addr[0];
					else
						enIntNext = cpu.addr[0];
				end
				3'd5: selectExtNext = cpu.addr[0];
				3'd6: q6Next = cpu.addr[0];
				default: q7Next = cpu.addr[0];
			endcase
		end
	end

	always_ff @(posedge clk8 or negedge _reset) begin
		if (!_reset) begin
			{ca0, ca1, ca2, lstrb} <= '0;
			{enInt, enExt, selectExt, q6, q7} <= '0;
			mode <= '0;
		end else begin
			{ca0, ca1, ca2, lstrb} <= {ca0Next, ca1Next, ca2Next, lstrbNext};
			{enInt, enExt, selectExt} <= {enIntNext, enExtNext, selectExtNext};
			{q6, q7} <= {q6Next, q7Next};
			if (modeWrite)
				mode <= iwmMode_t'(cpu.data[4:0]);
		end
	end

	// mode only takes writes while both motors are off
	assign modeWrite = cpu.strobe & cpu.write & q7Next & q6Next & ~(enInt | enExt);
	assign readStrobe = cpu.strobe & ~cpu.write & ~q7Next & ~q6Next; // data register read
	assign anyEnabled = enIntNext | enExtNext;

	// read-back follows the switches as updated by this access
	always_comb begin
		case ({q7Next, q6Next})
			2'b00: dataLo = latchByte;
			2'b01: dataLo = {sense, 1'b0, anyEnabled, mode};
			2'b10: dataLo = HandshakeIdle;
			default: dataLo = 8'h00; // mode register is write only
		endcase
	end
	assign dataOut = {DataOutHigh, dataLo};

	assign ctrlInt = '{ca0: ca0, ca1: ca1, ca2: ca2, lstrb: lstrb, sel: sel, enable: enInt};
	assign ctrlExt = '{ca0: ca0, ca1: ca1, ca2: ca2, lstrb: lstrb, sel: sel, enable: enExt};

endmodule

//--- iwm_chk.sv
// assertions bound into iwmRegs and readLatch; LatchSide picks the set, hold check needs the latch timer
`timescale 1ns/1ps

module iwm_chk #(
	parameter bit LatchSide = 1'b0  // 1 where bound into readLatch
) (
	input logic clk8,
	input logic _reset,
	input iwmPkg::driveCtrl_t ctrlA,
	input iwmPkg::driveCtrl_t ctrlB,
	input logic readStrobe,
	input logic [7:0] latchByte,
	input logic byteReady,
	input logic timerIdle     // clear timer not running
);

	if (!LatchSide) begin : regsSide
		// drive lines idle and latch empty as reset releases
		resetState: assert property (@(posedge clk8)
			$rose(_reset) |-> (ctrlA == '0 && ctrlB == '0 && latchByte == '0))
			else $error("drive controls or latch not inactive after reset");

		strobeWidth: assert property (@(posedge clk8) disable iff (!_reset)
			readStrobe |=> !readStrobe)
			else $error("readStrobe held for two cycles");
	end else begin : latchSide
		// qualifying read at t, no new byte through t+12, byte still there at t+13
		latchHold: assert property (@(posedge clk8) disable iff (!_reset)
			(readStrobe && latchByte[7] && timerIdle && !byteReady) ##1 (!byteReady [*12])
			|=> latchByte == $past(latchByte, 13))
			else $error("read latch changed before the clear delay ran out");
	end

endmodule

bind iwmRegs iwm_chk #(.LatchSide(1'b0)) regsChk (.clk8(clk8), ._reset(_reset),
	.ctrlA(ctrlInt), .ctrlB(ctrlExt), .readStrobe(readStrobe), .latchByte(latchByte),
	.byteReady(1'b0), .timerIdle(1'b0));

bind readLatch iwm_chk #(.LatchSide(1'b1)) latchChk (.clk8(clk8), ._reset(_reset),
	.ctrlA('0), .ctrlB('0), .readStrobe(readStrobe), .latchByte(latchByte),
	.byteReady(selected.byteReady), .timerIdle(clearTimer == '0));

//--- readLatch.sv
// read-data latch fed by whole bytes; no bit-cell sync, a new byte always replaces the old one
`timescale 1ns/1ps

module readLatch (
	input logic clk8,
	input logic _reset,
	input iwmPkg::driveStatus_t statusInt,
	input iwmPkg::driveStatus_t statusExt,
	input logic selectExt,
	input logic readStrobe,   // data register read, one cycle
	output logic [7:0] latchByte,
	output logic sense
);
	import iwmPkg::*;

	localparam int TimerW = $clog2(LatchClearCycles);
	// loaded on the read edge, latch clears on the edge where it reaches 1
	localparam logic [TimerW-1:0] TimerLoad = TimerW'(LatchClearCycles - 1);

	driveStatus_t selected;
	logic [TimerW-1:0] clearTimer;  // 0 = idle
	logic validRead;

	assign selected = selectExt ? statusExt : statusInt;
	assign sense = selected.sense;
	assign validRead = readStrobe & latchByte[7]; // MSB marks a valid byte

	always_ff @(posedge clk8 or negedge _reset) begin
		if (!_reset) begin
			latchByte <= '0;
			clearTimer <= '0;
		end else if (selected.byteReady) begin
			latchByte <= selected.readByte; // new byte beats the clear
			clearTimer <= '0;               // and cancels a pending one
		end else if (clearTimer == TimerW'(1)) begin
			latchByte <= '0;
			clearTimer <= '0;
		end else if (clearTimer != '0) begin
			clearTimer <= clearTimer - 1'b1;
		end else if (validRead) begin
			clearTimer <= TimerLoad; // later reads do not restart a running timer
		end
	end

endmodule

//--- tb_iwm.sv
// directed testbench for iwm; BytePeriod 64, inputs change 2 ns after the rising clk8 edge
`timescale 1ns/1ps

module tb_iwm;
	import iwmPkg::*;

	localparam int BytePeriod = 64;
	localparam int MaxPolls = 2 * BytePeriod;  // each poll is a read plus one idle cycle
	// five streamed bytes and setup stay under 1000 cycles, the rest is margin
	localparam int WatchdogCycles = 6000;

	logic clk8;
	logic _reset;
	cpuAccess_t cpu;
	logic sel;
	logic [1:0] insertDisk;
	logic [15:0] dataOut;
	logic [1:0] diskInDrive;

	int mismatches = 0;
	int failures = 0;           // timeouts while waiting on the DUT
	int seed = 63524;
	iwmMode_t lastMode = '0;    // last mode value written

	iwm #(.BytePeriod(BytePeriod)) DUT (
		.clk8(clk8),
		._reset(_reset),
		.cpu(cpu),
		.sel(sel),
		.insertDisk(insertDisk),
		.dataOut(dataOut),
		.diskInDrive(diskInDrive)
	);

	initial begin
		clk8 = 1'b0;
		forever #10 clk8 = ~clk8;
	end

	task automatic checkWord(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic checkDisk(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %b, got %b", name, expected, actual);
		end
	endtask

	// status byte: sense, 0, any motor on, mode
	function automatic logic [15:0] statusWord(input logic senseBit, input logic enabled);
		return {8'hBE, senseBit, 1'b0, enabled, lastMode};
	endfunction

	function automatic logic [7:0] expectedByte(input int trackSeed, input int k);
		return {1'b1, 7'(trackSeed + k)}; // MSB set, low seven bits count up
	endfunction

	task automatic nextCycle(input int n);
		repeat (n) @(posedge clk8);
		#2;  // back to the drive point
	endtask

	task automatic doAccess(input logic wr, input logic [3:0] addr, input logic [7:0] data,
		output logic [15:0] word);
		cpu = '{strobe: 1'b1, write: wr, addr: addr, data: data};
		@(negedge clk8);
		word = dataOut; // combinational read-back has settled by mid cycle
		nextCycle(1);
		cpu = '0;
	endtask

	// writes flip switches without raising readStrobe
	task automatic setSwitch(input logic [3:0] addr);
		logic [15:0] unused;
		doAccess(1'b1, addr, 8'h00, unused);
	endtask

	task automatic readData(output logic [15:0] word);
		doAccess(1'b0, 4'hE, 8'h00, word); // q7 off, q6 assumed off
	endtask

	task automatic readStatus(output logic [15:0] word);
		setSwitch(4'hE);
		doAccess(1'b0, 4'hD, 8'h00, word);  // q6 on with q7 off
	endtask

	task automatic peek(output logic [15:0] word);
		@(negedge clk8);
		word = dataOut;  // no access, shows current selection
		nextCycle(1);
	endtask

	task automatic insert(input logic [1:0] mask);
		insertDisk = mask;
		nextCycle(1);
		insertDisk = '0;
	endtask

	// index E on ca2..ca0 with sel low, then an lstrb pulse
	task automatic ejectDisks();
		setSwitch(4'h1);
		setSwitch(4'h3);
		setSwitch(4'h5);
		setSwitch(4'h7);
		setSwitch(4'h6);
		setSwitch(4'h4);
		setSwitch(4'h2);
		setSwitch(4'h0);
	endtask

	task automatic pollByte(input string name, output logic [15:0] word);
		int polls;
		polls = 0;
		readData(word);
		while (!word[7] && polls < MaxPolls) begin
			nextCycle(1); // gap so read strobes never touch
			readData(word);
			polls++;
		end
		if (!word[7]) begin
			failures++;
			$display("%s: no byte arrived from the drive", name);
		end
	endtask

	task automatic waitClear(input string name);
		logic [15:0] word;
		int n;
		n = 0;
		peek(word);
		while (word[7] && n < 4 * LatchClearCycles) begin
			peek(word);
			n++;
		end
		if (word[7]) begin
			failures++;
			$display("%s: read latch never cleared", name);
		end
	endtask

	task automatic handshakeAfterReset();
		logic [15:0] word;
		doAccess(1'b0, 4'hF, 8'h00, word); // q7 on, q6 still off
		checkWord("handshake", 16'hBEC0, word);
		doAccess(1'b0, 4'hE, 8'h00, word);
		checkWord("empty latch", 16'hBE00, word);
		checkDisk("no disks", 2'b00, diskInDrive);
	endtask

	task automatic modeReadback();
		logic [15:0] word;
		logic [31:0] randBits;
		repeat (4) begin
			randBits = $random(seed);
			lastMode = randBits[4:0];
			setSwitch(4'hF);
			doAccess(1'b1, 4'hD, {3'b000, lastMode}, word); // q7 q6 both on, motors off
			doAccess(1'b0, 4'hE, 8'h00, word);
			checkWord("mode readback", statusWord(1'b1, 1'b0), word);
			setSwitch(4'hC);
		end
	endtask

	task automatic insertAndEject();
		logic [15:0] word;
		insert(2'b01);
		checkDisk("internal inserted", 2'b01, diskInDrive);
		setSwitch(4'h1); // sense index 2
		readStatus(word);
		checkWord("sense disk present", statusWord(1'b0, 1'b0), word);
		ejectDisks();
		checkDisk("after eject", 2'b00, diskInDrive);
		setSwitch(4'h1);
		readStatus(word);
		checkWord("sense disk gone", statusWord(1'b1, 1'b0), word);
		setSwitch(4'h0);
		setSwitch(4'hC); // data register again
	endtask

	task automatic byteStream();
		logic [15:0] word;
		insert(2'b01);
		setSwitch(4'h9); // motor on, internal drive selected
		for (int k = 0; k < 3; k++) begin
			pollByte("stream", word);
			checkWord("stream", {8'hBE, expectedByte(0, k)}, word);
			waitClear("stream");
		end
	endtask

	task automatic latchClear();
		logic [15:0] word;
		pollByte("latch clear", word);  // this read is cycle t
		checkWord("latch clear byte", {8'hBE, expectedByte(0, 3)}, word);
		nextCycle(11);
		readData(word);
		checkWord("latch at t+12", {8'hBE, expectedByte(0, 3)}, word);
		peek(word);
		checkWord("latch at t+13", {8'hBE, expectedByte(0, 3)}, word);
		readData(word);
		checkWord("latch at t+14", 16'hBE00, word);
	endtask

	task automatic externalDrive();
		logic [15:0] word;
		setSwitch(4'h8); // internal motor off
		ejectDisks();
		checkDisk("both empty", 2'b00, diskInDrive);
		setSwitch(4'hB);
		insert(2'b10);
		checkDisk("external only", 2'b10, diskInDrive);
		setSwitch(4'h9);  // motor switch now reaches the external drive
		pollByte("external", word);
		checkWord("external first byte", {8'hBE, expectedByte(64, 0)}, word);
	endtask

	initial begin
		cpu = '0;
		sel = 1'b0;
		insertDisk = '0;
		_reset = 1'b0;
		nextCycle(2);
		_reset = 1'b1;
		handshakeAfterReset();
		modeReadback();
		insertAndEject();
		byteStream();
		latchClear();
		externalDrive();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk8);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule
